// File: run_sim.sh
#!/bin/sh
# Build and run the shell testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_shell -Mdir obj_dir -f verilog.f > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/Vtb_shell > sim.log 2>&1

# The log decides the result, the simulator exit code alone is not enough
grep -q "Simulation finished: PASS" sim.log \
    && echo "Test passed, see sim.log" \
    || { echo "Test failed, see sim.log"; exit 1; }

// File: src/axil_demux.sv
`default_nettype none

module axil_demux (
    input  logic                 aclk,
    input  logic                 aresetn,

    // Host side
    input  logic                 req_valid_i,
    input  shell_pkg::axil_req_t req_i,
    output logic                 req_ready_o,
    output logic                 rsp_valid_o,
    output shell_pkg::axil_rsp_t rsp_o,
    input  logic                 rsp_ready_i,

    // Firewall data port
    output logic                 emu_req_valid_o,
    output shell_pkg::axil_req_t emu_req_o,
    input  logic                 emu_req_ready_i,
    input  logic                 emu_rsp_valid_i,
    input  shell_pkg::axil_rsp_t emu_rsp_i,
    output logic                 emu_rsp_ready_o,

    // Firewall management port
    output logic                 mgmt_req_valid_o,
    output shell_pkg::axil_req_t mgmt_req_o,
    input  logic                 mgmt_req_ready_i,
    input  logic                 mgmt_rsp_valid_i,
    input  shell_pkg::axil_rsp_t mgmt_rsp_i,
    output logic                 mgmt_rsp_ready_o
);

    import shell_pkg::*;

    xact_state_e state_q;
    region_e     region_q;
    region_e     region_d;
    axil_req_t   req_q;
    axil_rsp_t   rsp_q;
    logic        req_hs;
    logic        sel_req_ready;
    logic        sel_rsp_valid;
    axil_rsp_t   sel_rsp;

    function automatic region_e decode_region(input logic [ADDR_W-1:0] addr);
        region_e r;
        if ((addr & REGION0_MASK) == REGION0_BASE)
            r = REG_EMU;
        else if ((addr & REGION1_MASK) == REGION1_BASE)
            r = REG_CLKGEN;
        else if ((addr & REGION2_MASK) == REGION2_BASE)
            r = REG_MGMT;
        else
            r = REG_NONE;
        return r;
    endfunction

    assign region_d = decode_region(req_i.addr);
    assign req_hs   = req_valid_i && (state_q == ST_IDLE);

    // Port selected by the captured region
    assign sel_req_ready = (region_q == REG_MGMT) ? mgmt_req_ready_i : emu_req_ready_i;
    assign sel_rsp_valid = (region_q == REG_MGMT) ? mgmt_rsp_valid_i : emu_rsp_valid_i;
    assign sel_rsp       = (region_q == REG_MGMT) ? mgmt_rsp_i : emu_rsp_i;

    // ==================================================
    // Channel outputs
    // ==================================================
    assign req_ready_o      = (state_q == ST_IDLE);
    assign rsp_valid_o      = (state_q == ST_RESP);
    assign rsp_o            = rsp_q;

    assign emu_req_valid_o  = (state_q == ST_REQ) && (region_q == REG_EMU);
    assign emu_req_o        = req_q;
    assign emu_rsp_ready_o  = (state_q == ST_WAIT) && (region_q == REG_EMU);

    assign mgmt_req_valid_o = (state_q == ST_REQ) && (region_q == REG_MGMT);
    assign mgmt_req_o       = req_q;
    assign mgmt_rsp_ready_o = (state_q == ST_WAIT) && (region_q == REG_MGMT);

    // ==================================================
    // Transaction FSM
    // ==================================================
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state_q  <= ST_IDLE;
            region_q <= REG_NONE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (req_hs) begin
                        region_q <= region_d;
                        // Unmapped regions skip straight to the error reply
                        if (region_d == REG_EMU || region_d == REG_MGMT)
                            state_q <= ST_REQ;
                        else
                            state_q <= ST_RESP;
                    end
                end
                ST_REQ: begin
                    if (sel_req_ready)
                        state_q <= ST_WAIT;
                end
                ST_WAIT: begin
                    if (sel_rsp_valid)
                        state_q <= ST_RESP;
                end
                default: begin
                    if (rsp_ready_i)
                        state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // Request and response holding registers
    always_ff @(posedge aclk) begin
        if (req_hs) begin
            req_q <= req_i;
            rsp_q <= '{rdata: '0, resp: RESP_DECERR};
        end else if (state_q == ST_WAIT && sel_rsp_valid) begin
            rsp_q <= sel_rsp;
        end
    end

endmodule

`default_nettype wire

// File: src/axil_firewall.sv
`default_nettype none

module axil_firewall (
    input  logic                 aclk,
    input  logic                 aresetn,

    // Data port from the demux
    input  logic                 s_req_valid_i,
    input  shell_pkg::axil_req_t s_req_i,
    output logic                 s_req_ready_o,
    output logic                 s_rsp_valid_o,
    output shell_pkg::axil_rsp_t s_rsp_o,
    input  logic                 s_rsp_ready_i,

    // Toward the emulation target
    output logic                 m_req_valid_o,
    output shell_pkg::axil_req_t m_req_o,
    input  logic                 m_req_ready_i,
    input  logic                 m_rsp_valid_i,
    input  shell_pkg::axil_rsp_t m_rsp_i,
    output logic                 m_rsp_ready_o,

    // Management registers
    input  logic                 mgmt_req_valid_i,
    input  shell_pkg::axil_req_t mgmt_req_i,
    output logic                 mgmt_req_ready_o,
    output logic                 mgmt_rsp_valid_o,
    output shell_pkg::axil_rsp_t mgmt_rsp_o,
    input  logic                 mgmt_rsp_ready_i
);

    import shell_pkg::*;

    xact_state_e             state_q;
    axil_req_t               req_q;
    axil_rsp_t               rsp_q;
    logic                    s_req_hs;
    logic                    decouple_q;
    logic [DATA_W-1:0]       blocked_cnt_q;

    logic                    mgmt_hs;
    logic                    mgmt_rsp_valid_q;
    axil_rsp_t               mgmt_rsp_q;
    axil_rsp_t               mgmt_rsp_d;
    logic [MGMT_OFS_W-1:0]   mgmt_ofs;

    // ==================================================
    // Data path
    // ==================================================
    assign s_req_hs      = s_req_valid_i && (state_q == ST_IDLE);
    assign s_req_ready_o = (state_q == ST_IDLE);
    assign s_rsp_valid_o = (state_q == ST_RESP);
    assign s_rsp_o       = rsp_q;

    assign m_req_valid_o = (state_q == ST_REQ);
    assign m_req_o       = req_q;
    assign m_rsp_ready_o = (state_q == ST_WAIT);

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state_q       <= ST_IDLE;
            blocked_cnt_q <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (s_req_hs) begin
                        // Decoupled target: answer locally and count it
                        if (decouple_q) begin
                            state_q       <= ST_RESP;
                            blocked_cnt_q <= blocked_cnt_q + 1'b1;
                        end else begin
                            state_q <= ST_REQ;
                        end
                    end
                end
                ST_REQ: begin
                    if (m_req_ready_i)
                        state_q <= ST_WAIT;
                end
                ST_WAIT: begin
                    if (m_rsp_valid_i)
                        state_q <= ST_RESP;
                end
                default: begin
                    if (s_rsp_ready_i)
                        state_q <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (s_req_hs) begin
            req_q <= s_req_i;
            rsp_q <= '{rdata: '0, resp: RESP_SLVERR};
        end else if (state_q == ST_WAIT && m_rsp_valid_i) begin
            rsp_q <= m_rsp_i;
        end
    end

    // ==================================================
    // Management registers
    // ==================================================
    assign mgmt_ofs         = mgmt_req_i.addr[MGMT_OFS_W-1:0];
    assign mgmt_hs          = mgmt_req_valid_i && !mgmt_rsp_valid_q;
    assign mgmt_req_ready_o = !mgmt_rsp_valid_q;
    assign mgmt_rsp_valid_o = mgmt_rsp_valid_q;
    assign mgmt_rsp_o       = mgmt_rsp_q;

    // Read value and status for the offset being accepted
    always_comb begin
        mgmt_rsp_d = '{rdata: '0, resp: RESP_OKAY};
        case (mgmt_ofs)
            FW_CTRL_OFS:    mgmt_rsp_d.rdata = {{(DATA_W-1){1'b0}}, decouple_q};
            FW_BLOCKED_OFS: mgmt_rsp_d.rdata = blocked_cnt_q;
            default:        mgmt_rsp_d.resp  = RESP_SLVERR;
        endcase
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            mgmt_rsp_valid_q <= 1'b0;
            decouple_q       <= 1'b0;
        end else if (mgmt_hs) begin
            mgmt_rsp_valid_q <= 1'b1;
            if (mgmt_req_i.write && mgmt_ofs == FW_CTRL_OFS && mgmt_req_i.wstrb[0])
                decouple_q <= mgmt_req_i.wdata[0];
        end else if (mgmt_rsp_ready_i) begin
            mgmt_rsp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (mgmt_hs)
            mgmt_rsp_q <= mgmt_rsp_d;
    end

endmodule

`default_nettype wire

// File: src/emu_regs.sv
`default_nettype none

module emu_regs (
    input  logic                        aclk,
    input  logic                        aresetn,

    input  logic                        req_valid_i,
    input  shell_pkg::axil_req_t        req_i,
    output logic                        req_ready_o,
    output logic                        rsp_valid_o,
    output shell_pkg::axil_rsp_t        rsp_o,
    input  logic                        rsp_ready_i,

    output logic [shell_pkg::N_IRQ-1:0] irq_o,
    output logic                        finish_o
);

    import shell_pkg::*;

    logic [DATA_W-1:0]            regs_q [EMU_NREGS];
    logic [$clog2(EMU_NREGS)-1:0] idx;
    logic                         req_hs;
    logic                         rsp_valid_q;
    axil_rsp_t                    rsp_q;

    // Word index, upper region bits alias
    assign idx = req_i.addr[2 +: $clog2(EMU_NREGS)];

    assign req_hs      = req_valid_i && !rsp_valid_q;
    assign req_ready_o = !rsp_valid_q;
    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o       = rsp_q;

    // ==================================================
    // Register file
    // ==================================================
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < EMU_NREGS; i++)
                regs_q[i] <= '0;
        end else if (req_hs && req_i.write) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (req_i.wstrb[b])
                    regs_q[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
            end
        end
    end

    // One response per accepted request
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn)
            rsp_valid_q <= 1'b0;
        else if (req_hs)
            rsp_valid_q <= 1'b1;
        else if (rsp_ready_i)
            rsp_valid_q <= 1'b0;
    end

    always_ff @(posedge aclk) begin
        if (req_hs)
            rsp_q <= '{rdata: regs_q[idx], resp: RESP_OKAY};
    end

    // Sideband outputs straight from the registers
    assign irq_o    = regs_q[EMU_IRQ_IDX][N_IRQ-1:0];
    assign finish_o = regs_q[EMU_FINISH_IDX][0];

endmodule

`default_nettype wire

// File: src/shell_pkg.sv
`default_nettype none

package shell_pkg;

    // ==================================================
    // Bus widths
    // ==================================================
    localparam int ADDR_W     = 20;
    localparam int DATA_W     = 32;
    localparam int STRB_W     = DATA_W / 8;
    localparam int N_IRQ      = 16;
    localparam int MGMT_OFS_W = 16;

    // ==================================================
    // Address map
    // ==================================================
    // Emulation target, 0x0_0000 to 0x3_FFFF
    localparam logic [ADDR_W-1:0] REGION0_BASE = 20'h0_0000;
    localparam logic [ADDR_W-1:0] REGION0_MASK = 20'hC_0000;
    // Old clock generator DRP window, now unmapped
    localparam logic [ADDR_W-1:0] REGION1_BASE = 20'h4_0000;
    localparam logic [ADDR_W-1:0] REGION1_MASK = 20'hF_0000;
    // Firewall management registers
    localparam logic [ADDR_W-1:0] REGION2_BASE = 20'h5_0000;
    localparam logic [ADDR_W-1:0] REGION2_MASK = 20'hF_0000;

    // Firewall management offsets
    localparam logic [MGMT_OFS_W-1:0] FW_CTRL_OFS    = 16'h0000;
    localparam logic [MGMT_OFS_W-1:0] FW_BLOCKED_OFS = 16'h0004;

    // Emulation target register file
    localparam int EMU_NREGS      = 16;
    localparam int EMU_IRQ_IDX    = 0;
    localparam int EMU_FINISH_IDX = 1;

    // ==================================================
    // Enums
    // ==================================================
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_SLVERR = 2'd2,
        RESP_DECERR = 2'd3
    } axil_resp_e;

    typedef enum logic [1:0] {
        REG_EMU,
        REG_CLKGEN,
        REG_MGMT,
        REG_NONE
    } region_e;

    // Phases of a single outstanding transaction
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT,
        ST_RESP
    } xact_state_e;

    // ==================================================
    // Folded AXI-Lite channels
    // ==================================================
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              write;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] wstrb;
    } axil_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        axil_resp_e        resp;
    } axil_rsp_t;

endpackage

`default_nettype wire

// File: src/shell_top.sv
`default_nettype none

module shell_top (
    input  logic                        aclk,
    input  logic                        aresetn,

    // Host register port
    input  logic                        req_valid_i,
    input  shell_pkg::axil_req_t        req_i,
    output logic                        req_ready_o,
    output logic                        rsp_valid_o,
    output shell_pkg::axil_rsp_t        rsp_o,
    input  logic                        rsp_ready_i,

    // Emulation sideband
    output logic [shell_pkg::N_IRQ-1:0] irq_o,
    output logic                        finish_o
);

    import shell_pkg::*;

    // ==================================================
    // Demux to firewall
    // ==================================================
    logic      dmx_emu_req_valid;
    axil_req_t dmx_emu_req;
    logic      dmx_emu_req_ready;
    logic      dmx_emu_rsp_valid;
    axil_rsp_t dmx_emu_rsp;
    logic      dmx_emu_rsp_ready;

    logic      dmx_mgmt_req_valid;
    axil_req_t dmx_mgmt_req;
    logic      dmx_mgmt_req_ready;
    logic      dmx_mgmt_rsp_valid;
    axil_rsp_t dmx_mgmt_rsp;
    logic      dmx_mgmt_rsp_ready;

    // Firewall to target
    logic      fw_req_valid;
    axil_req_t fw_req;
    logic      fw_req_ready;
    logic      fw_rsp_valid;
    axil_rsp_t fw_rsp;
    logic      fw_rsp_ready;

    axil_demux u_demux (
        .aclk             (aclk),
        .aresetn          (aresetn),
        .req_valid_i      (req_valid_i),
        .req_i            (req_i),
        .req_ready_o      (req_ready_o),
        .rsp_valid_o      (rsp_valid_o),
        .rsp_o            (rsp_o),
        .rsp_ready_i      (rsp_ready_i),
        .emu_req_valid_o  (dmx_emu_req_valid),
        .emu_req_o        (dmx_emu_req),
        .emu_req_ready_i  (dmx_emu_req_ready),
        .emu_rsp_valid_i  (dmx_emu_rsp_valid),
        .emu_rsp_i        (dmx_emu_rsp),
        .emu_rsp_ready_o  (dmx_emu_rsp_ready),
        .mgmt_req_valid_o (dmx_mgmt_req_valid),
        .mgmt_req_o       (dmx_mgmt_req),
        .mgmt_req_ready_i (dmx_mgmt_req_ready),
        .mgmt_rsp_valid_i (dmx_mgmt_rsp_valid),
        .mgmt_rsp_i       (dmx_mgmt_rsp),
        .mgmt_rsp_ready_o (dmx_mgmt_rsp_ready)
    );

    axil_firewall u_firewall (
        .aclk             (aclk),
        .aresetn          (aresetn),
        .s_req_valid_i    (dmx_emu_req_valid),
        .s_req_i          (dmx_emu_req),
        .s_req_ready_o    (dmx_emu_req_ready),
        .s_rsp_valid_o    (dmx_emu_rsp_valid),
        .s_rsp_o          (dmx_emu_rsp),
        .s_rsp_ready_i    (dmx_emu_rsp_ready),
        .m_req_valid_o    (fw_req_valid),
        .m_req_o          (fw_req),
        .m_req_ready_i    (fw_req_ready),
        .m_rsp_valid_i    (fw_rsp_valid),
        .m_rsp_i          (fw_rsp),
        .m_rsp_ready_o    (fw_rsp_ready),
        .mgmt_req_valid_i (dmx_mgmt_req_valid),
        .mgmt_req_i       (dmx_mgmt_req),
        .mgmt_req_ready_o (dmx_mgmt_req_ready),
        .mgmt_rsp_valid_o (dmx_mgmt_rsp_valid),
        .mgmt_rsp_o       (dmx_mgmt_rsp),
        .mgmt_rsp_ready_i (dmx_mgmt_rsp_ready)
    );

    // Stand-in for the emulation top
    emu_regs u_emu_regs (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .req_valid_i (fw_req_valid),
        .req_i       (fw_req),
        .req_ready_o (fw_req_ready),
        .rsp_valid_o (fw_rsp_valid),
        .rsp_o       (fw_rsp),
        .rsp_ready_i (fw_rsp_ready),
        .irq_o       (irq_o),
        .finish_o    (finish_o)
    );

endmodule

`default_nettype wire

// File: tests/shell_checker.sv
`default_nettype none

module shell_checker (
    input  logic                        aclk,
    input  logic                        aresetn,
    input  logic                        req_ready_i,
    input  logic                        rsp_valid_i,
    input  shell_pkg::axil_rsp_t        rsp_i,
    input  logic                        rsp_ready_i,
    input  logic [shell_pkg::N_IRQ-1:0] irq_i,
    input  logic                        finish_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // Number of failed assertions
    int fail_cnt = 0;

    // ==================================================
    // Host response channel
    // ==================================================
    // A pending response holds until the host takes it
    rsp_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_i))
        else begin
            fail_cnt++;
            $error("host response changed or dropped before rsp_ready");
        end

    // One outstanding transaction at a time
    busy_not_ready: assert property (@(posedge aclk) disable iff (!aresetn)
        rsp_valid_i |-> !req_ready_i)
        else begin
            fail_cnt++;
            $error("req_ready high while a response is pending");
        end

    // ==================================================
    // Sideband after reset
    // ==================================================
    reset_outputs: assert property (@(posedge aclk)
        $rose(aresetn) |-> (irq_i == '0) && !finish_i)
        else begin
            fail_cnt++;
            $error("irq_o or finish_o not cleared after reset");
        end

endmodule

`default_nettype wire

// File: tests/shell_stim.txt
# op addr wdata wstrb exp_rdata exp_resp, all hex; op 1 is a write, 0 a read
# resp 0 OKAY, 2 SLVERR, 3 DECERR; exp_rdata is not checked on writes
1 00008 12345678 f 00000000 0
0 00008 00000000 0 12345678 0
1 00008 aabbccdd 5 00000000 0
0 00008 00000000 0 12bb56dd 0
0 10008 00000000 0 12bb56dd 0
1 00000 deadbeef 3 00000000 0
0 00000 00000000 0 0000beef 0
1 00004 00000001 1 00000000 0
0 00004 00000000 0 00000001 0
0 40000 00000000 0 00000000 3
1 40010 cafef00d f 00000000 3
0 60000 00000000 0 00000000 3
1 ffffc 11111111 f 00000000 3
0 50000 00000000 0 00000000 0
0 50004 00000000 0 00000000 0
1 50000 00000001 1 00000000 0
0 50000 00000000 0 00000001 0
0 00008 00000000 0 00000000 2
1 00008 ffffffff f 00000000 2
0 00000 00000000 0 00000000 2
0 50004 00000000 0 00000003 0
1 50004 12345678 f 00000000 0
0 50004 00000000 0 00000003 0
0 50008 00000000 0 00000000 2
1 50010 00000000 f 00000000 2
1 50000 00000000 e 00000000 0
0 50000 00000000 0 00000001 0
1 50000 00000000 1 00000000 0
0 00008 00000000 0 12bb56dd 0
0 00000 00000000 0 0000beef 0
1 00000 00000000 f 00000000 0
0 50004 00000000 0 00000003 0

// File: tests/tb_shell.sv
`default_nettype none

module tb_shell;

    timeunit 1ns;
    timeprecision 1ps;

    import shell_pkg::*;

    logic              aclk;
    logic              aresetn;
    logic              req_valid_i;
    axil_req_t         req_i;
    logic              req_ready_o;
    logic              rsp_valid_o;
    axil_rsp_t         rsp_o;
    logic              rsp_ready_i;
    logic [N_IRQ-1:0]  irq_o;
    logic              finish_o;

    // Stimulus columns, one entry per transaction
    logic [31:0] stim_op[$];
    logic [31:0] stim_addr[$];
    logic [31:0] stim_wdata[$];
    logic [31:0] stim_wstrb[$];
    logic [31:0] stim_rdata[$];
    logic [31:0] stim_resp[$];

    // Expected contents of the target registers seen through irq_o and finish_o
    logic [31:0] shadow [16];

    logic [31:0] lfsr_q;
    int          errors;
    int          checks;
    int          assert_errors;
    int          cycle_cnt;
    int          cycle_limit;
    bit          load_ok;

    shell_top dut (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .req_ready_o (req_ready_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o),
        .rsp_ready_i (rsp_ready_i),
        .irq_o       (irq_o),
        .finish_o    (finish_o)
    );

    bind shell_top shell_checker u_checker (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .req_ready_i (req_ready_o),
        .rsp_valid_i (rsp_valid_o),
        .rsp_i       (rsp_o),
        .rsp_ready_i (rsp_ready_i),
        .irq_i       (irq_o),
        .finish_i    (finish_o)
    );

    // ==================================================
    // Clock and watchdog
    // ==================================================
    initial aclk = 1'b0;
    always #4 aclk = ~aclk;

    always @(posedge aclk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT did not finish a transaction",
                     cycle_cnt);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // ==================================================
    // Helpers
    // ==================================================
    task automatic step();
        @(posedge aclk);
        #1;
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        else
            return s >> 1;
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int k = 0; k < n; k++) begin
            value  = {value[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp, input int txn);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t ns: txn %0d %s got %h expected %h",
                     $time, txn, what, got, exp);
        end
    endtask

    task automatic load_stim(output bit ok);
        int    fd;
        int    fields;
        string line;
        logic [31:0] op, addr, wdata, wstrb, rdata, resp;
        ok = 1'b0;
        fd = $fopen("tests/shell_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file tests/shell_stim.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() == 0 || line.getc(0) == "#")
                    continue;
                fields = $sscanf(line, "%h %h %h %h %h %h",
                                 op, addr, wdata, wstrb, rdata, resp);
                if (fields == 6) begin
                    stim_op.push_back(op);
                    stim_addr.push_back(addr);
                    stim_wdata.push_back(wdata);
                    stim_wstrb.push_back(wstrb);
                    stim_rdata.push_back(rdata);
                    stim_resp.push_back(resp);
                end
            end
            $fclose(fd);
            if (stim_op.size() == 0)
                $display("The stimulus file holds no transactions");
            else
                ok = 1'b1;
        end
    endtask

    // Target window is 0x0_0000 to 0x3_FFFF, bytes follow the strobe
    task automatic update_shadow(input int i);
        logic [3:0] idx;
        idx = stim_addr[i][5:2];
        if (stim_resp[i] == 32'h0 && stim_addr[i][19:18] == 2'b00) begin
            for (int b = 0; b < 4; b++) begin
                if (stim_wstrb[i][b])
                    shadow[idx][8*b +: 8] = stim_wdata[i][8*b +: 8];
            end
        end
    endtask

    // ==================================================
    // One host transaction
    // ==================================================
    task automatic run_txn(input int i);
        logic        is_write;
        logic [31:0] delay;
        is_write    = stim_op[i][0];
        req_i.addr  = stim_addr[i][ADDR_W-1:0];
        req_i.write = is_write;
        req_i.wdata = stim_wdata[i];
        req_i.wstrb = stim_wstrb[i][STRB_W-1:0];
        req_valid_i = 1'b1;
        while (!req_ready_o)
            step();
        step();
        req_valid_i = 1'b0;
        if (is_write)
            update_shadow(i);

        while (!rsp_valid_o)
            step();
        // Random back-pressure of 0 to 3 cycles
        draw_bits(2, delay);
        repeat (delay)
            step();
        rsp_ready_i = 1'b1;

        // Write responses carry no data
        if (!is_write)
            check_value("rdata", rsp_o.rdata, stim_rdata[i], i);
        check_value("resp", 32'(rsp_o.resp), stim_resp[i], i);
        if (is_write) begin
            check_value("irq_o", 32'(irq_o), {16'h0, shadow[0][15:0]}, i);
            check_value("finish_o", 32'(finish_o), {31'h0, shadow[1][0]}, i);
        end
        step();
        rsp_ready_i = 1'b0;
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        aresetn       = 1'b0;
        req_valid_i   = 1'b0;
        req_i         = '0;
        rsp_ready_i   = 1'b0;
        errors        = 0;
        checks        = 0;
        assert_errors = 0;
        cycle_cnt     = 0;
        cycle_limit   = 0;
        lfsr_q        = 32'h77d0_1f42;
        for (int r = 0; r < 16; r++)
            shadow[r] = '0;

        load_stim(load_ok);
        if (!load_ok) begin
            $display("Simulation finished: FAIL");
            $finish;
        end else begin
            cycle_limit = 40 * stim_op.size() + 100;

            // Reset held for 5 cycles
            repeat (5) @(posedge aclk);
            #1;
            aresetn = 1'b1;
            step();

            for (int i = 0; i < stim_op.size(); i++)
                run_txn(i);
            step();

            assert_errors = dut.u_checker.fail_cnt;
            $display("Transactions: %0d  checks: %0d  errors: %0d  assertion failures: %0d",
                     stim_op.size(), checks, errors, assert_errors);
            if (errors == 0 && assert_errors == 0)
                $display("Simulation finished: PASS");
            else
                $display("Simulation finished: FAIL");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verilog.f
src/shell_pkg.sv
src/axil_demux.sv
src/axil_firewall.sv
src/emu_regs.sv
src/shell_top.sv
tests/shell_checker.sv
tests/tb_shell.sv
